/* verilog.f */
logic/adder_pkg.sv
logic/stage_if.sv
logic/gp_prefix_16.sv
logic/adder_16.sv
logic/addsub_front.sv
logic/addsub_back.sv
logic/addsub_unit.sv
tb/tb_addsub.sv

/* Makefile */
SIM        = verilator
TOP        = tb_addsub
RTL_TOP    = addsub_unit
FILELIST   = verilog.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing -j 0 --timescale 1ns/10ps --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing -Wall --timescale 1ns/10ps --top-module $(RTL_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

# the binary exits non-zero when the testbench stops with $fatal
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_addsub.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_addsub import adder_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_OPS      = 2000;
    localparam logic [31:0] SEED         = 32'hbd6b_9515;
    // about one idle cycle in four, so two cycles per operation is ample
    localparam int          WATCHDOG_NS  = (NUM_OPS * 2 + RESET_CYCLES + 100) * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    logic                  op;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] result;
    logic                  carry;
    logic                  overflow;
    logic                  zero;

    logic [DATA_WIDTH-1:0] exp_result_q[$];
    logic                  exp_carry_q[$];
    logic                  exp_overflow_q[$];
    logic                  exp_zero_q[$];
    int                    issue_cycle_q[$];
    int                    cycle_count;
    int                    ops_issued;
    int                    ops_checked;

    addsub_unit u_addsub_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .carry     (carry),
        .overflow  (overflow),
        .zero      (zero)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string field, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, field, got, expected);
            stop_run();
        end
    endtask

    task automatic check_flag(input string field, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, field, got, expected);
            stop_run();
        end
    endtask

    // 33-bit sum of a, the conditioned b and the carry-in gives all four results
    task automatic predict_and_queue(input logic op_v, input logic [DATA_WIDTH-1:0] a_v,
                                     input logic [DATA_WIDTH-1:0] b_v);
        logic                  is_sub;
        logic [DATA_WIDTH-1:0] b_eff;
        logic [DATA_WIDTH:0]   full;
        logic [DATA_WIDTH-1:0] r;
        logic                  ovf;
        is_sub = (op_v == OP_SUB);
        b_eff  = is_sub ? ~b_v : b_v;
        full   = {1'b0, a_v} + {1'b0, b_eff} + {{DATA_WIDTH{1'b0}}, is_sub};
        r      = full[DATA_WIDTH-1:0];
        // the two addends share a sign bit and the result sign differs from it
        ovf    = (a_v[DATA_WIDTH-1] == b_eff[DATA_WIDTH-1]) &&
                 (r[DATA_WIDTH-1] != a_v[DATA_WIDTH-1]);
        exp_result_q.push_back(r);
        exp_carry_q.push_back(full[DATA_WIDTH]);
        exp_overflow_q.push_back(ovf);
        exp_zero_q.push_back(r == '0);
        issue_cycle_q.push_back(cycle_count);
    endtask

    // runs at the falling edge, where the registered outputs are settled
    task automatic check_outputs();
        int age;
        if (out_valid !== 1'b0) begin
            if (issue_cycle_q.size() == 0) begin
                $display("out_valid went high at %0t with no operation outstanding", $time);
                stop_run();
            end else begin
                age = cycle_count - issue_cycle_q.pop_front();
                if (age != PIPE_LATENCY) begin
                    $display("out_valid came %0d cycles after its operation instead of %0d",
                             age, PIPE_LATENCY);
                    stop_run();
                end else begin
                    check_word("result", result, exp_result_q.pop_front());
                    check_flag("carry", carry, exp_carry_q.pop_front());
                    check_flag("overflow", overflow, exp_overflow_q.pop_front());
                    check_flag("zero", zero, exp_zero_q.pop_front());
                    ops_checked++;
                end
            end
        end else if (issue_cycle_q.size() != 0 &&
                     cycle_count - issue_cycle_q[0] >= PIPE_LATENCY) begin
            $display("out_valid stayed low at %0t for an outstanding operation", $time);
            stop_run();
        end
    endtask

    task automatic issue_op(input logic op_v, input logic [DATA_WIDTH-1:0] a_v,
                            input logic [DATA_WIDTH-1:0] b_v);
        @(negedge clk);
        cycle_count++;
        check_outputs();
        in_valid = 1'b1;
        op       = op_v;
        a        = a_v;
        b        = b_v;
        predict_and_queue(op_v, a_v, b_v);
        ops_issued++;
    endtask

    // operands still toggle while in_valid is low and must not leak into results
    task automatic idle_cycle();
        logic [31:0] r;
        @(negedge clk);
        cycle_count++;
        check_outputs();
        r        = $urandom;
        in_valid = 1'b0;
        op       = r[0];
        a        = $urandom;
        b        = $urandom;
    endtask

    task automatic random_cycle();
        logic [31:0]           ctl;
        logic [DATA_WIDTH-1:0] ra;
        logic [DATA_WIDTH-1:0] rb;
        ctl = $urandom;
        ra  = $urandom;
        rb  = $urandom;
        // an all-ones low half forces the low carry across into stage two
        if (ctl[5:3] == 3'd0) begin
            ra[HALF_WIDTH-1:0] = '1;
        end
        if (ctl[8:6] == 3'd0) begin
            rb = ra;
        end
        if (ctl[1:0] != 2'b00) begin
            issue_op(ctl[2], ra, rb);
        end else begin
            idle_cycle();
        end
    endtask

    task automatic run_directed();
        issue_op(OP_ADD, 32'h0000_ffff, 32'h0000_0001);
        issue_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        issue_op(OP_SUB, 32'h8000_0000, 32'h0000_0001);
        issue_op(OP_SUB, 32'h1234_5678, 32'h1234_5678);
        issue_op(OP_ADD, 32'hffff_ffff, 32'h0000_0001);
        issue_op(OP_SUB, 32'h0000_0000, 32'h0000_0001);
        issue_op(OP_ADD, 32'h8000_0000, 32'h8000_0000);
        idle_cycle();
        // alternating ops back to back keep two different operations in flight
        issue_op(OP_ADD, 32'h0001_ffff, 32'h0000_ffff);
        issue_op(OP_SUB, 32'h0001_ffff, 32'h0000_ffff);
        issue_op(OP_ADD, 32'hffff_0000, 32'h0001_0000);
        issue_op(OP_SUB, 32'h0000_0000, 32'h8000_0000);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with %0d of %0d operations checked",
                 WATCHDOG_NS, ops_checked, NUM_OPS);
        stop_run();
    end

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        op          = OP_ADD;
        a           = '0;
        b           = '0;
        cycle_count = 0;
        ops_issued  = 0;
        ops_checked = 0;
        repeat (RESET_CYCLES) idle_cycle();
        rst_n = 1'b1;
        repeat (3) idle_cycle();
        run_directed();
        while (ops_issued < NUM_OPS) begin
            random_cycle();
        end
        repeat (PIPE_LATENCY + 1) idle_cycle();
        if (issue_cycle_q.size() != 0) begin
            $display("%0d operations never produced out_valid", issue_cycle_q.size());
            stop_run();
        end else begin
            $display("%0d operations checked", ops_checked);
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* logic/addsub_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module addsub_unit import adder_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  op,
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  carry,
    output logic                  overflow,
    output logic                  zero
);

    // low half is added in the first stage, high half and flags in the second
    stage_if u_stage_if ();

    addsub_front u_addsub_front (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op       (op),
        .a        (a),
        .b        (b),
        .stage    (u_stage_if.front)
    );

    addsub_back u_addsub_back (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage     (u_stage_if.back),
        .out_valid (out_valid),
        .result    (result),
        .carry     (carry),
        .overflow  (overflow),
        .zero      (zero)
    );

endmodule

`default_nettype wire

/* logic/addsub_back.sv */
`timescale 1ns/10ps
`default_nettype none

module addsub_back import adder_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    stage_if.back                 stage,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  carry,
    output logic                  overflow,
    output logic                  zero
);

    logic [HALF_WIDTH-1:0] hi_sum;
    logic                  hi_carry;
    logic [DATA_WIDTH-1:0] result_next;
    logic                  a_sign;
    logic                  b_sign;
    logic                  r_sign;
    logic                  overflow_next;

    adder_16 u_adder_hi (
        .a    (stage.a_hi),
        .b    (stage.b_hi),
        .cin  (stage.lo_carry),
        .sum  (hi_sum),
        .cout (hi_carry)
    );

    assign result_next = {hi_sum, stage.lo_sum};

    assign a_sign = stage.a_hi[HALF_WIDTH-1];
    // b_hi arrives inverted for a subtraction, undo that for the original sign
    assign b_sign = stage.b_hi[HALF_WIDTH-1] ^ stage.sub;
    assign r_sign = hi_sum[HALF_WIDTH-1];

    // a subtraction overflows when the operand signs differ, an addition when they match
    assign overflow_next = (stage.sub ? (a_sign != b_sign) : (a_sign == b_sign))
                           && (r_sign != a_sign);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= stage.valid;
        end
    end

    // for a subtraction the carry out is set when no borrow occurred
    always_ff @(posedge clk) begin
        if (stage.valid) begin
            result   <= result_next;
            carry    <= hi_carry;
            overflow <= overflow_next;
            zero     <= ~|result_next;
        end
    end

endmodule

`default_nettype wire

/* logic/addsub_front.sv */
`timescale 1ns/10ps
`default_nettype none

module addsub_front import adder_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  op,
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    stage_if.front                stage
);

    logic                  sub;
    logic [DATA_WIDTH-1:0] b_cond;
    logic [HALF_WIDTH-1:0] lo_sum;
    logic                  lo_carry;

    // a - b is computed as a + ~b + 1, the +1 enters as the low carry-in
    assign sub    = (op == OP_SUB);
    assign b_cond = sub ? ~b : b;

    adder_16 u_adder_lo (
        .a    (a[HALF_WIDTH-1:0]),
        .b    (b_cond[HALF_WIDTH-1:0]),
        .cin  (sub),
        .sum  (lo_sum),
        .cout (lo_carry)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= in_valid;
        end
    end

    // the high operands travel on so stage two can finish the add
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage.sub      <= sub;
            stage.lo_sum   <= lo_sum;
            stage.lo_carry <= lo_carry;
            stage.a_hi     <= a[DATA_WIDTH-1:HALF_WIDTH];
            stage.b_hi     <= b_cond[DATA_WIDTH-1:HALF_WIDTH];
        end
    end

endmodule

`default_nettype wire

/* logic/adder_16.sv */
`timescale 1ns/10ps
`default_nettype none

module adder_16 import adder_pkg::*; (
    input  logic [HALF_WIDTH-1:0] a,
    input  logic [HALF_WIDTH-1:0] b,
    input  logic                  cin,
    output logic [HALF_WIDTH-1:0] sum,
    output logic                  cout
);

    logic [HALF_WIDTH-1:0] bit_p;
    logic [HALF_WIDTH-1:0] bit_g;
    logic [HALF_WIDTH-1:0] group_p;
    logic [HALF_WIDTH-1:0] group_g;
    // carry[i] is the carry into bit i, carry[HALF_WIDTH] leaves the adder
    logic [HALF_WIDTH:0]   carry;

    assign bit_p = a ^ b;
    assign bit_g = a & b;

    gp_prefix_16 u_gp_prefix_16 (
        .p       (bit_p),
        .g       (bit_g),
        .group_p (group_p),
        .group_g (group_g)
    );

    assign carry[0] = cin;

    // the tree sees no carry-in, so cin is folded in at each position here
    for (genvar i = 0; i < HALF_WIDTH; i++) begin : g_carry
        assign carry[i+1] = group_g[i] | (group_p[i] & cin);
    end

    assign sum  = bit_p ^ carry[HALF_WIDTH-1:0];
    assign cout = carry[HALF_WIDTH];

endmodule

`default_nettype wire

/* logic/gp_prefix_16.sv */
`timescale 1ns/10ps
`default_nettype none

module gp_prefix_16 import adder_pkg::*; (
    input  logic [HALF_WIDTH-1:0] p,
    input  logic [HALF_WIDTH-1:0] g,
    output logic [HALF_WIDTH-1:0] group_p,
    output logic [HALF_WIDTH-1:0] group_g
);

    // bits are numbered 1 to 16 inside the tree
    logic [HALF_WIDTH:1] p_l0, g_l0;
    logic [HALF_WIDTH:1] p_l1, g_l1;
    logic [HALF_WIDTH:1] p_l2, g_l2;
    logic [HALF_WIDTH:1] p_l3, g_l3;
    logic [HALF_WIDTH:1] p_l4, g_l4;
    logic [HALF_WIDTH:1] p_l5, g_l5;
    logic [HALF_WIDTH:1] p_l6, g_l6;
    logic [HALF_WIDTH:1] p_l7, g_l7;

    assign p_l0 = p;
    assign g_l0 = g;

    // up-sweep, pairs at distance 1, 2, 4 and 8
    for (genvar i = 1; i <= HALF_WIDTH; i++) begin : g_up1
        if (i % 2 == 0) begin : g_node
            assign p_l1[i] = p_l0[i-1] & p_l0[i];
            assign g_l1[i] = g_l0[i] | (g_l0[i-1] & p_l0[i]);
        end else begin : g_pass
            assign p_l1[i] = p_l0[i];
            assign g_l1[i] = g_l0[i];
        end
    end

    for (genvar i = 1; i <= HALF_WIDTH; i++) begin : g_up2
        if (i % 4 == 0) begin : g_node
            assign p_l2[i] = p_l1[i-2] & p_l1[i];
            assign g_l2[i] = g_l1[i] | (g_l1[i-2] & p_l1[i]);
        end else begin : g_pass
            assign p_l2[i] = p_l1[i];
            assign g_l2[i] = g_l1[i];
        end
    end

    for (genvar i = 1; i <= HALF_WIDTH; i++) begin : g_up3
        if (i % 8 == 0) begin : g_node
            assign p_l3[i] = p_l2[i-4] & p_l2[i];
            assign g_l3[i] = g_l2[i] | (g_l2[i-4] & p_l2[i]);
        end else begin : g_pass
            assign p_l3[i] = p_l2[i];
            assign g_l3[i] = g_l2[i];
        end
    end

    // after this level bit 16 holds the full group term
    for (genvar i = 1; i <= HALF_WIDTH; i++) begin : g_up4
        if (i % 16 == 0) begin : g_node
            assign p_l4[i] = p_l3[i-8] & p_l3[i];
            assign g_l4[i] = g_l3[i] | (g_l3[i-8] & p_l3[i]);
        end else begin : g_pass
            assign p_l4[i] = p_l3[i];
            assign g_l4[i] = g_l3[i];
        end
    end

    // down-sweep fills in the remaining positions at distance 4, 2 and 1
    for (genvar i = 1; i <= HALF_WIDTH; i++) begin : g_dn4
        if (i >= 12 && (i - 12) % 8 == 0) begin : g_node
            assign p_l5[i] = p_l4[i-4] & p_l4[i];
            assign g_l5[i] = g_l4[i] | (g_l4[i-4] & p_l4[i]);
        end else begin : g_pass
            assign p_l5[i] = p_l4[i];
            assign g_l5[i] = g_l4[i];
        end
    end

    for (genvar i = 1; i <= HALF_WIDTH; i++) begin : g_dn2
        if (i >= 6 && (i - 6) % 4 == 0) begin : g_node
            assign p_l6[i] = p_l5[i-2] & p_l5[i];
            assign g_l6[i] = g_l5[i] | (g_l5[i-2] & p_l5[i]);
        end else begin : g_pass
            assign p_l6[i] = p_l5[i];
            assign g_l6[i] = g_l5[i];
        end
    end

    // every odd position above 1 takes the completed even position below it
    for (genvar i = 1; i <= HALF_WIDTH; i++) begin : g_dn1
        if (i >= 3 && (i - 3) % 2 == 0) begin : g_node
            assign p_l7[i] = p_l6[i-1] & p_l6[i];
            assign g_l7[i] = g_l6[i] | (g_l6[i-1] & p_l6[i]);
        end else begin : g_pass
            assign p_l7[i] = p_l6[i];
            assign g_l7[i] = g_l6[i];
        end
    end

    assign group_p = p_l7;
    assign group_g = g_l7;

endmodule

`default_nettype wire

/* logic/stage_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface stage_if import adder_pkg::*; ();

    // one operation in flight between the two pipeline stages
    logic                  valid;
    logic                  sub;
    logic [HALF_WIDTH-1:0] lo_sum;
    logic                  lo_carry;
    logic [HALF_WIDTH-1:0] a_hi;
    // already inverted when sub is set
    logic [HALF_WIDTH-1:0] b_hi;

    modport front (
        output valid,
        output sub,
        output lo_sum,
        output lo_carry,
        output a_hi,
        output b_hi
    );

    modport back (
        input valid,
        input sub,
        input lo_sum,
        input lo_carry,
        input a_hi,
        input b_hi
    );

endinterface

`default_nettype wire

/* logic/adder_pkg.sv */
`default_nettype none

package adder_pkg;

    // operand and result width of the whole unit
    localparam int DATA_WIDTH = 32;

    // width of one prefix adder, and so of each pipeline half
    localparam int HALF_WIDTH = 16;

    // the operation select is a single bit
    localparam logic OP_ADD = 1'b0;
    localparam logic OP_SUB = 1'b1;

    // cycles from the input strobe to the output pulse
    // one register stage sits in addsub_front and one in addsub_back
    localparam int PIPE_LATENCY = 2;

endpackage

`default_nettype wire
